/* source/pifo_pkg.sv */
`default_nettype none

package pifo_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    localparam int RANK_W     = 4;
    localparam int PAYLOAD_W  = 8;
    localparam int MAX_LEVELS = 6;
    localparam int COUNT_W    = MAX_LEVELS + 1;  // Root slot holds up to 2**MAX_LEVELS - 1

    // ---------------------------------------------------------------------
    // Entry and node word
    // ---------------------------------------------------------------------
    typedef logic [RANK_W-1:0]    rank_t;     // Smaller rank leaves first
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [COUNT_W-1:0]   count_t;

    typedef struct packed {
        payload_t payload;
        rank_t    rank;       // Low bits of the entry
    } entry_t;

    typedef struct packed {
        count_t count;        // Entries in this slot's subtree, slot included
        entry_t entry;
    } slot_t;

    typedef struct packed {
        slot_t slot1;
        slot_t slot0;
    } node_word_t;

    localparam rank_t  EMPTY_RANK  = '1;
    localparam entry_t EMPTY_ENTRY = '{payload: '0, rank: EMPTY_RANK};
    localparam slot_t  EMPTY_SLOT  = '{count: '0, entry: EMPTY_ENTRY};

    // Level FSM with neighbouring states one bit apart
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PUSH = 2'b01,
        ST_POP  = 2'b11,
        ST_WB   = 2'b10
    } level_state_e;

endpackage

`default_nettype wire

/* source/pifo_host_port.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_host_port #(
    parameter int LEVELS = 3
) (
    input  wire               i_clk,
    input  wire               i_arst_n,
    input  wire               i_push,
    input  wire               i_pop,
    input  pifo_pkg::rank_t    i_rank,
    input  pifo_pkg::payload_t i_payload,
    output logic              o_ready,
    output logic              o_full,
    output logic              o_empty,
    output logic              o_push_cmd,
    output logic              o_pop_cmd,
    output pifo_pkg::entry_t   o_push_entry,
    output logic              o_pop_pending
);
    import pifo_pkg::*;

    // Two slots per node, 2**k nodes on level k
    localparam int CAPACITY = 2 ** (LEVELS + 1) - 2;
    localparam int OCC_W    = $clog2(CAPACITY + 1);

    logic [OCC_W-1:0] occ_q;
    logic [1:0]       gap_q;    // Cycles left before the next command

    // ----------------------------------------------------------------------
    // Acceptance
    // ----------------------------------------------------------------------
    assign o_ready = (gap_q == 2'd0);
    assign o_full  = (occ_q == OCC_W'(CAPACITY));
    assign o_empty = (occ_q == '0);

    // Pop has priority over a simultaneous push
    assign o_pop_cmd  = i_pop & o_ready & ~o_empty;
    assign o_push_cmd = i_push & ~i_pop & o_ready & ~o_full;

    assign o_push_entry = '{payload: i_payload, rank: i_rank};

    // ----------------------------------------------------------------------
    // Occupancy and command spacing
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            occ_q         <= '0;
            gap_q         <= 2'd0;
            o_pop_pending <= 1'b0;
        end else begin
            o_pop_pending <= o_pop_cmd;  // Root shows the entry next cycle
            if (o_pop_cmd) begin
                occ_q <= occ_q - 1'b1;
                gap_q <= 2'd2;           // Covers ST_POP and ST_WB at the root
            end else if (o_push_cmd) begin
                occ_q <= occ_q + 1'b1;
                gap_q <= 2'd1;           // Root write-back of the push
            end else if (gap_q != 2'd0) begin
                gap_q <= gap_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/pifo_level_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_level_ram #(
    parameter int  LEVEL_IDX = 0,
    localparam int ADDR_W    = (LEVEL_IDX == 0) ? 1 : LEVEL_IDX
) (
    input  wire                 i_clk,
    input  wire                 i_arst_n,
    input  wire                 i_rd_en,
    input  wire [ADDR_W-1:0]    i_rd_addr,
    input  wire                 i_wr_en,
    input  wire [ADDR_W-1:0]    i_wr_addr,
    input  pifo_pkg::node_word_t i_wr_word,
    output pifo_pkg::node_word_t o_rd_word
);
    import pifo_pkg::*;

    localparam int DEPTH = 2 ** LEVEL_IDX;  // One word per node on this level
    localparam node_word_t EMPTY_WORD = '{slot1: EMPTY_SLOT, slot0: EMPTY_SLOT};

    node_word_t mem [DEPTH];

    // Flop array so the whole tree starts empty
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= EMPTY_WORD;
            o_rd_word <= EMPTY_WORD;
        end else begin
            if (i_wr_en)
                mem[i_wr_addr] <= i_wr_word;
            if (i_rd_en)
                o_rd_word <= mem[i_rd_addr];  // Held until the next read
        end
    end

endmodule

`default_nettype wire

/* source/pifo_level.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_level #(
    parameter int  LEVELS    = 3,
    parameter int  LEVEL_IDX = 0,
    localparam int ADDR_W    = (LEVEL_IDX == 0) ? 1 : LEVEL_IDX
) (
    input  wire                   i_clk,
    input  wire                   i_arst_n,
    // From parent
    input  wire                   i_push,
    input  pifo_pkg::entry_t       i_push_entry,
    input  wire                   i_pop,
    input  wire [ADDR_W-1:0]      i_addr,
    output pifo_pkg::entry_t       o_pop_entry,
    // To child
    input  pifo_pkg::entry_t       i_child_pop_entry,
    output logic                  o_child_push,
    output pifo_pkg::entry_t       o_child_push_entry,
    output logic                  o_child_pop,
    output logic [LEVEL_IDX:0]    o_child_addr,
    // Level memory
    output logic                  o_rd_en,
    output logic [ADDR_W-1:0]     o_rd_addr,
    input  pifo_pkg::node_word_t   i_rd_word,
    output logic                  o_wr_en,
    output logic [ADDR_W-1:0]     o_wr_addr,
    output pifo_pkg::node_word_t   o_wr_word
);
    import pifo_pkg::*;

    localparam bit IS_LEAF = (LEVEL_IDX >= LEVELS - 1);

    level_state_e      state_q;
    level_state_e      state_d;
    entry_t            entry_q;   // Entry carried by the pending push
    logic [ADDR_W-1:0] addr_q;

    logic   cmd_take;
    logic   push_sel;
    logic   pop_sel;
    logic   sel;
    slot_t  sel_slot;
    slot_t  new_slot;
    logic   child_push;
    logic   child_pop;
    entry_t child_push_entry;
    logic   [ADDR_W:0] child_addr_full;

    // ----------------------------------------------------------------------
    // Command intake and FSM
    // ----------------------------------------------------------------------
    // Parent never issues a command while this level is in ST_POP
    assign cmd_take  = (i_push | i_pop) & (state_q != ST_POP);
    assign o_rd_en   = cmd_take;
    assign o_rd_addr = i_addr;

    always_comb begin
        state_d = ST_IDLE;
        if (state_q == ST_POP) begin
            state_d = ST_WB;
        end else if (i_pop) begin
            state_d = ST_POP;
        end else if (i_push) begin
            state_d = ST_PUSH;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge i_clk) begin
        if (cmd_take) begin
            entry_q <= i_push_entry;
            addr_q  <= i_addr;
        end
    end

    // ----------------------------------------------------------------------
    // Slot choice
    // ----------------------------------------------------------------------
    // Push goes to the emptier subtree, pop takes the smaller rank
    assign push_sel = (i_rd_word.slot1.count < i_rd_word.slot0.count);
    assign pop_sel  = (i_rd_word.slot1.entry.rank < i_rd_word.slot0.entry.rank);
    assign sel      = (state_q == ST_PUSH) ? push_sel : pop_sel;
    assign sel_slot = sel ? i_rd_word.slot1 : i_rd_word.slot0;

    always_comb begin
        new_slot         = sel_slot;
        o_wr_en          = 1'b0;
        child_push       = 1'b0;
        child_push_entry = entry_q;
        child_pop        = 1'b0;
        o_pop_entry      = EMPTY_ENTRY;
        case (state_q)
            ST_PUSH: begin
                o_wr_en        = 1'b1;
                new_slot.count = sel_slot.count + 1'b1;
                if (sel_slot.entry.rank == EMPTY_RANK) begin
                    new_slot.entry = entry_q;          // Lands here, nothing goes down
                end else begin
                    child_push = 1'b1;
                    if (entry_q.rank < sel_slot.entry.rank) begin
                        new_slot.entry   = entry_q;
                        child_push_entry = sel_slot.entry;
                    end
                end
            end
            ST_POP: begin
                o_pop_entry = sel_slot.entry;
                child_pop   = 1'b1;
            end
            ST_WB: begin
                o_wr_en        = 1'b1;
                new_slot.entry = i_child_pop_entry;    // Empty rank if child had none
                if (sel_slot.count != '0)
                    new_slot.count = sel_slot.count - 1'b1;
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------------------
    // Write-back and child side
    // ----------------------------------------------------------------------
    always_comb begin
        o_wr_word = i_rd_word;
        if (sel)
            o_wr_word.slot1 = new_slot;
        else
            o_wr_word.slot0 = new_slot;
    end

    assign o_wr_addr = addr_q;

    assign child_addr_full = {addr_q, sel};
    assign o_child_addr    = child_addr_full[LEVEL_IDX:0];  // Root word address is dropped

    assign o_child_push       = IS_LEAF ? 1'b0 : child_push;
    assign o_child_pop        = IS_LEAF ? 1'b0 : child_pop;
    assign o_child_push_entry = child_push_entry;

endmodule

`default_nettype wire

/* source/pifo_pop_out.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_pop_out (
    input  wire               i_clk,
    input  wire               i_arst_n,
    input  wire               i_capture,
    input  pifo_pkg::entry_t   i_entry,
    output logic              o_pop_valid,
    output pifo_pkg::rank_t    o_pop_rank,
    output pifo_pkg::payload_t o_pop_payload
);
    import pifo_pkg::*;

    rank_t    rank_q;
    payload_t payload_q;

    // Single-cycle strobe without back-pressure
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            o_pop_valid <= 1'b0;
        else
            o_pop_valid <= i_capture;
    end

    // Last popped entry stays visible between pops
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            rank_q    <= i_entry.rank;
            payload_q <= i_entry.payload;
        end
    end

    assign o_pop_rank    = rank_q;
    assign o_pop_payload = payload_q;

endmodule

`default_nettype wire

/* source/pifo_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_top #(
    parameter int LEVELS = 3
) (
    input  wire               i_clk,
    input  wire               i_arst_n,
    input  wire               i_push,
    input  wire               i_pop,
    input  pifo_pkg::rank_t    i_rank,
    input  pifo_pkg::payload_t i_payload,
    output logic              o_ready,
    output logic              o_full,
    output logic              o_empty,
    output logic              o_pop_valid,
    output pifo_pkg::rank_t    o_pop_rank,
    output pifo_pkg::payload_t o_pop_payload
);
    import pifo_pkg::*;

    if (LEVELS < 1 || LEVELS > MAX_LEVELS) begin : g_bad_depth
        $error("pifo_top: LEVELS out of range");
    end

    // Chain between levels where index k is the input side of level k
    logic              lvl_push       [LEVELS];
    logic              lvl_pop        [LEVELS];
    entry_t            lvl_push_entry [LEVELS];
    entry_t            lvl_pop_entry  [LEVELS];
    logic [LEVELS-1:0] lvl_addr       [LEVELS];
    logic              pop_pending;

    pifo_host_port #(
        .LEVELS (LEVELS)
    ) i_host_port (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_push        (i_push),
        .i_pop         (i_pop),
        .i_rank        (i_rank),
        .i_payload     (i_payload),
        .o_ready       (o_ready),
        .o_full        (o_full),
        .o_empty       (o_empty),
        .o_push_cmd    (lvl_push[0]),
        .o_pop_cmd     (lvl_pop[0]),
        .o_push_entry  (lvl_push_entry[0]),
        .o_pop_pending (pop_pending)
    );

    assign lvl_addr[0] = '0;  // Single word at the root

    // ----------------------------------------------------------------------
    // Level chain
    // ----------------------------------------------------------------------
    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        localparam int AW = (k == 0) ? 1 : k;

        logic        child_push;
        logic        child_pop;
        entry_t      child_push_entry;
        entry_t      child_ret;
        logic [k:0]  child_addr;
        logic        rd_en;
        logic        wr_en;
        logic [AW-1:0] rd_addr;
        logic [AW-1:0] wr_addr;
        node_word_t  rd_word;
        node_word_t  wr_word;

        pifo_level #(
            .LEVELS    (LEVELS),
            .LEVEL_IDX (k)
        ) i_level (
            .i_clk              (i_clk),
            .i_arst_n           (i_arst_n),
            .i_push             (lvl_push[k]),
            .i_push_entry       (lvl_push_entry[k]),
            .i_pop              (lvl_pop[k]),
            .i_addr             (lvl_addr[k][AW-1:0]),
            .o_pop_entry        (lvl_pop_entry[k]),
            .i_child_pop_entry  (child_ret),
            .o_child_push       (child_push),
            .o_child_push_entry (child_push_entry),
            .o_child_pop        (child_pop),
            .o_child_addr       (child_addr),
            .o_rd_en            (rd_en),
            .o_rd_addr          (rd_addr),
            .i_rd_word          (rd_word),
            .o_wr_en            (wr_en),
            .o_wr_addr          (wr_addr),
            .o_wr_word          (wr_word)
        );

        pifo_level_ram #(
            .LEVEL_IDX (k)
        ) i_ram (
            .i_clk     (i_clk),
            .i_arst_n  (i_arst_n),
            .i_rd_en   (rd_en),
            .i_rd_addr (rd_addr),
            .i_wr_en   (wr_en),
            .i_wr_addr (wr_addr),
            .i_wr_word (wr_word),
            .o_rd_word (rd_word)
        );

        if (k < LEVELS - 1) begin : g_link
            assign lvl_push[k+1]       = child_push;
            assign lvl_pop[k+1]        = child_pop;
            assign lvl_push_entry[k+1] = child_push_entry;
            assign lvl_addr[k+1]       = {{(LEVELS - k - 1){1'b0}}, child_addr};
            assign child_ret           = lvl_pop_entry[k+1];
        end else begin : g_leaf
            assign child_ret = EMPTY_ENTRY;  // Nothing below the last level
        end
    end

    pifo_pop_out i_pop_out (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_capture     (pop_pending),
        .i_entry       (lvl_pop_entry[0]),
        .o_pop_valid   (o_pop_valid),
        .o_pop_rank    (o_pop_rank),
        .o_pop_payload (o_pop_payload)
    );

endmodule

`default_nettype wire

/* testbench/pifo_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_sva (
    input wire i_clk,
    input wire i_arst_n,
    input wire i_push,
    input wire i_pop,
    input wire i_ready,
    input wire i_full,
    input wire i_empty,
    input wire i_pop_valid
);
    int unsigned fail_count = 0;  // Read by the testbench

    logic push_acc;
    logic pop_acc;

    // Host acceptance with pop before push
    assign pop_acc  = i_pop & i_ready & ~i_empty;
    assign push_acc = i_push & ~i_pop & i_ready & ~i_full;

    // ---------------------------------------------------------------------
    // Command spacing and pop timing
    // ---------------------------------------------------------------------
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        push_acc |=> !i_ready ##1 i_ready)
    else begin
        $error("ready gap after push is not one cycle");
        fail_count++;
    end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        pop_acc |=> !i_ready ##1 !i_ready ##1 i_ready)
    else begin
        $error("ready gap after pop is not two cycles");
        fail_count++;
    end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        pop_acc |-> ##2 i_pop_valid)
    else begin
        $error("pop valid missing two cycles after pop");
        fail_count++;
    end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pop_valid |-> $past(pop_acc, 2))
    else begin
        $error("pop valid without an accepted pop");
        fail_count++;
    end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_full && i_empty))
    else begin
        $error("full and empty both high");
        fail_count++;
    end

endmodule

`default_nettype wire

/* testbench/pifo_checks.svh */
`ifndef PIFO_CHECKS_SVH
`define PIFO_CHECKS_SVH

// ---------------------------------------------------------------------
// Popped entry
// ---------------------------------------------------------------------
task automatic check_entry(
    input rank_t    exp_rank,
    input payload_t exp_payload,
    input bit       with_payload,  // Only when the rank is unique
    input rank_t    got_rank,
    input payload_t got_payload
);
    if (got_rank !== exp_rank)
        report_failure($sformatf("ERR o_pop_rank: expected 0x%h, got 0x%h in row %0d",
                                 exp_rank, got_rank, cur_row));
    if (with_payload && got_payload !== exp_payload)
        report_failure($sformatf("ERR o_pop_payload: expected 0x%h, got 0x%h in row %0d",
                                 exp_payload, got_payload, cur_row));
endtask

// ---------------------------------------------------------------------
// Status flags and strobes
// ---------------------------------------------------------------------
task automatic check_flags(
    input logic exp_full,
    input logic exp_empty,
    input logic got_full,
    input logic got_empty
);
    if (got_full !== exp_full)
        report_failure($sformatf("ERR o_full: expected 0x%h, got 0x%h in row %0d",
                                 exp_full, got_full, cur_row));
    if (got_empty !== exp_empty)
        report_failure($sformatf("ERR o_empty: expected 0x%h, got 0x%h in row %0d",
                                 exp_empty, got_empty, cur_row));
endtask

task automatic check_bit(input string name, input logic exp_value, input logic got_value);
    if (got_value !== exp_value)
        report_failure($sformatf("ERR %s: expected 0x%h, got 0x%h in row %0d",
                                 name, exp_value, got_value, cur_row));
endtask

`endif

/* testbench/pifo_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pifo_tb;
    import pifo_pkg::*;

    localparam int LEVELS   = 3;
    localparam int CAPACITY = 14;  // Two slots on each of the 7 nodes

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_PUSH,
        OP_POP
    } op_e;

    typedef struct packed {
        op_e      op;
        rank_t    rank;
        payload_t payload;
        rank_t    exp_rank;     // EMPTY_RANK when nothing may come out
        payload_t exp_payload;
        logic     exp_full;
        logic     exp_empty;
        logic     from_model;   // Expected values filled in at run time
    } row_t;

    logic     i_clk;
    logic     i_arst_n;
    logic     i_push;
    logic     i_pop;
    rank_t    i_rank;
    payload_t i_payload;
    logic     o_ready;
    logic     o_full;
    logic     o_empty;
    logic     o_pop_valid;
    rank_t    o_pop_rank;
    payload_t o_pop_payload;

    row_t   rows [$];
    entry_t model_q [$];  // Stored entries, unordered
    int     cur_row       = -1;
    int     cycle_count   = 0;
    int     timeout_limit = 0;

    // Fill with repeated ranks where the last push finds the queue full
    rank_t fill_ranks [15] = '{4'd6, 4'd3, 4'd12, 4'd3, 4'd9, 4'd1, 4'd14, 4'd8,
                               4'd3, 4'd10, 4'd0, 4'd5, 4'd13, 4'd8, 4'd4};
    op_e   mix_ops [16]    = '{OP_PUSH, OP_PUSH, OP_POP, OP_PUSH, OP_PUSH, OP_POP,
                               OP_POP, OP_PUSH, OP_PUSH, OP_POP, OP_PUSH, OP_POP,
                               OP_POP, OP_POP, OP_POP, OP_IDLE};
    rank_t mix_ranks [16]  = '{4'd8, 4'd3, 4'd0, 4'd3, 4'd12, 4'd0, 4'd0, 4'd1,
                               4'd6, 4'd0, 4'd6, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0};

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    `include "pifo_checks.svh"

    pifo_top #(
        .LEVELS (LEVELS)
    ) i_pifo_top (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_push        (i_push),
        .i_pop         (i_pop),
        .i_rank        (i_rank),
        .i_payload     (i_payload),
        .o_ready       (o_ready),
        .o_full        (o_full),
        .o_empty       (o_empty),
        .o_pop_valid   (o_pop_valid),
        .o_pop_rank    (o_pop_rank),
        .o_pop_payload (o_pop_payload)
    );

    bind pifo_top pifo_sva i_sva (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_push      (i_push),
        .i_pop       (i_pop),
        .i_ready     (o_ready),
        .i_full      (o_full),
        .i_empty     (o_empty),
        .i_pop_valid (o_pop_valid)
    );

    function automatic int unsigned bound_failures();
        return i_pifo_top.i_sva.fail_count;
    endfunction

    // ---------------------------------------------------------------------
    // Stimulus table
    // ---------------------------------------------------------------------
    function automatic void add_row(op_e op, rank_t rank, payload_t payload, rank_t exp_rank,
                                    payload_t exp_payload, logic exp_full, logic exp_empty);
        row_t row;
        row = '{op, rank, payload, exp_rank, exp_payload, exp_full, exp_empty, 1'b0};
        rows.push_back(row);
    endfunction

    function automatic void add_fill(op_e op, rank_t rank);
        row_t row;
        row = '{op, rank, payload_t'($urandom()), EMPTY_RANK, 8'h00, 1'b0, 1'b0, 1'b1};
        rows.push_back(row);
    endfunction

    function automatic void build_table();
        add_row(OP_POP,  4'd0,  8'h00, EMPTY_RANK, 8'h00, 1'b0, 1'b1);  // Dropped on empty
        add_row(OP_IDLE, 4'd0,  8'h00, EMPTY_RANK, 8'h00, 1'b0, 1'b1);
        add_row(OP_PUSH, 4'd7,  8'h3C, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_PUSH, 4'd2,  8'h91, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_PUSH, 4'd11, 8'h5E, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_PUSH, 4'd5,  8'hC4, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_PUSH, 4'd0,  8'h27, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_PUSH, 4'd9,  8'hB8, EMPTY_RANK, 8'h00, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd0,       8'h27, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd2,       8'h91, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd5,       8'hC4, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd7,       8'h3C, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd9,       8'hB8, 1'b0, 1'b0);
        add_row(OP_POP,  4'd0,  8'h00, 4'd11,      8'h5E, 1'b0, 1'b1);
        foreach (fill_ranks[i])
            add_fill(OP_PUSH, fill_ranks[i]);
        repeat (CAPACITY + 1)
            add_fill(OP_POP, 4'd0);
        foreach (mix_ops[i])
            add_fill(mix_ops[i], mix_ranks[i]);
    endfunction

    // ---------------------------------------------------------------------
    // Reference model
    // ---------------------------------------------------------------------
    function automatic int model_min_index();
        int idx;
        idx = -1;
        foreach (model_q[i]) begin
            if (idx < 0 || model_q[i].rank < model_q[idx].rank)
                idx = i;
        end
        return idx;
    endfunction

    function automatic int model_rank_count(rank_t rank);
        int n;
        n = 0;
        foreach (model_q[i]) begin
            if (model_q[i].rank == rank)
                n++;
        end
        return n;
    endfunction

    // Removes the popped entry and needs a payload match when ranks tie
    function automatic bit model_take(rank_t rank, payload_t payload, bit any_payload);
        int idx;
        idx = -1;
        foreach (model_q[i]) begin
            if (idx < 0 && model_q[i].rank == rank &&
                (any_payload || model_q[i].payload == payload))
                idx = i;
        end
        if (idx >= 0)
            model_q.delete(idx);
        return idx >= 0;
    endfunction

    task automatic apply_row(input row_t row);
        row_t exp;
        int   idx;
        int   size_after;
        bit   unique_rank;
        exp         = row;
        idx         = model_min_index();
        unique_rank = (idx >= 0) ? (model_rank_count(model_q[idx].rank) == 1) : 1'b0;
        size_after  = model_q.size();
        if (row.op == OP_PUSH && size_after < CAPACITY)
            size_after++;
        else if (row.op == OP_POP && size_after > 0)
            size_after--;
        if (row.from_model) begin
            exp.exp_rank    = EMPTY_RANK;
            exp.exp_payload = '0;
            if (row.op == OP_POP && idx >= 0) begin
                exp.exp_rank    = model_q[idx].rank;
                exp.exp_payload = model_q[idx].payload;
            end
            exp.exp_full  = (size_after == CAPACITY);
            exp.exp_empty = (size_after == 0);
        end
        if (row.op == OP_PUSH && model_q.size() < CAPACITY)
            model_q.push_back('{payload: row.payload, rank: row.rank});

        while (!o_ready)
            @(negedge i_clk);
        i_push    = (row.op == OP_PUSH);
        i_pop     = (row.op == OP_POP);
        i_rank    = row.rank;
        i_payload = row.payload;
        @(negedge i_clk);
        i_push = 1'b0;
        i_pop  = 1'b0;
        check_flags(exp.exp_full, exp.exp_empty, o_full, o_empty);
        if (row.op == OP_POP) begin
            check_bit("o_pop_valid", 1'b0, o_pop_valid);
            @(negedge i_clk);  // Entry shows two cycles after acceptance
            check_bit("o_pop_valid", exp.exp_rank != EMPTY_RANK, o_pop_valid);
            if (exp.exp_rank != EMPTY_RANK) begin
                check_entry(exp.exp_rank, exp.exp_payload, unique_rank,
                            o_pop_rank, o_pop_payload);
                if (!model_take(o_pop_rank, o_pop_payload, unique_rank))
                    report_failure($sformatf("ERR o_pop_payload: 0x%h not stored with rank 0x%h",
                                             o_pop_payload, o_pop_rank));
            end
        end
    endtask

    // ---------------------------------------------------------------------
    // Clock, timeout and main sequence
    // ---------------------------------------------------------------------
    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
        cycle_count <= cycle_count + 1;

    initial begin
        wait (timeout_limit != 0);
        wait (cycle_count >= timeout_limit);
        report_failure($sformatf("Timeout: test did not finish within %0d cycles", timeout_limit));
    end

    always @(negedge i_clk) begin
        if (bound_failures() != 0)
            report_failure("An assertion bound to pifo_top failed");
    end

    initial begin
        i_arst_n  = 1'b0;
        i_push    = 1'b0;
        i_pop     = 1'b0;
        i_rank    = '0;
        i_payload = '0;
        void'($urandom(42229));
        build_table();
        timeout_limit = 5 * rows.size() + 50;
        repeat (4) @(negedge i_clk);
        i_arst_n = 1'b1;

        check_bit("o_ready", 1'b1, o_ready);
        check_bit("o_pop_valid", 1'b0, o_pop_valid);
        check_flags(1'b0, 1'b1, o_full, o_empty);

        foreach (rows[r]) begin
            cur_row = r;
            apply_row(rows[r]);
        end
        repeat (3) @(negedge i_clk);  // Let trailing assertions settle

        if (bound_failures() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure("An assertion bound to pifo_top failed");
        end
    end

endmodule

`default_nettype wire

/* pifo_top.f */
+incdir+testbench
source/pifo_pkg.sv
source/pifo_host_port.sv
source/pifo_level_ram.sv
source/pifo_level.sv
source/pifo_pop_out.sv
source/pifo_top.sv
testbench/pifo_sva.sv
testbench/pifo_tb.sv

/* Bender.yml */
package:
  name: pifo

sources:
  - source/pifo_pkg.sv
  - source/pifo_host_port.sv
  - source/pifo_level_ram.sv
  - source/pifo_level.sv
  - source/pifo_pop_out.sv
  - source/pifo_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/pifo_sva.sv
      - testbench/pifo_tb.sv
